/* hdl/dac_lvds_pkg.sv */
// widths, types, serializer words and timing constants
// for the dual dac lvds output path.
`default_nettype none

package dac_lvds_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // serializer and sample geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SER_RATIO = 8;
  localparam int SAMPLE_W  = 16;
  // one lane per sample bit.
  localparam int LANES     = SAMPLE_W;
  localparam int BIT_POS_W = $clog2(SER_RATIO);

  typedef logic [SER_RATIO-1:0]          ser_word_t;
  // sign in the msb, magnitude below.
  typedef logic [SAMPLE_W-1:0]           sample_t;
  // s0 sits in the lowest SAMPLE_W bits.
  typedef logic [SER_RATIO*SAMPLE_W-1:0] dds_word_t;
  typedef logic [LANES-1:0]              lane_bus_t;
  typedef logic [BIT_POS_W-1:0]          bit_pos_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed serializer words.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam ser_word_t DCLK_PATTERN = 8'b1010_1010;
  localparam ser_word_t SYNC_IDLE    = 8'b1111_1111;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reset release and delay calibration.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int RST_STAGES = 10;
  localparam int RDY_CYCLES = 16;
  localparam int RDY_CNT_W  = $clog2(RDY_CYCLES + 1);

  typedef logic [RDY_CNT_W-1:0] rdy_cnt_t;

  // tap count, 0 to 511.
  localparam int TAP_W          = 9;
  localparam int TAPS_PER_STAGE = 64;
  localparam int DELAY_STAGES   = 8;

  typedef logic [TAP_W-1:0]                tap_t;
  typedef logic [$clog2(DELAY_STAGES)-1:0] stage_sel_t;

endpackage

`default_nettype wire

/* hdl/lvds_reset_ctrl.sv */
// reset-release shift register and delay
// controller ready counter.
`timescale 1ns/1ps
`default_nettype none

module lvds_reset_ctrl (
  input  wire  clk_500m,
  input  wire  rst_n,
  output logic lane_rst,
  output logic delay_rdy
);
  import dac_lvds_pkg::*;

  // ones on reset, zeros walk in from the top.
  logic [RST_STAGES-1:0] rst_sr;
  rdy_cnt_t              rdy_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // synchronous release of the async reset.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_500m or negedge rst_n)
  begin
    if (!rst_n)
      rst_sr <= '1;
    else
      rst_sr <= {1'b0, rst_sr[RST_STAGES-1:1]};
  end

  // lowest stage drives every lane reset.
  assign lane_rst = rst_sr[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // calibration count before ready.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_500m or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdy_cnt   <= '0;
      delay_rdy <= 1'b0;
    end
    else if (lane_rst)
    begin
      rdy_cnt   <= '0;
      delay_rdy <= 1'b0;
    end
    else if (!delay_rdy)
    begin
      rdy_cnt <= rdy_cnt + 1'b1;
      // last count sets ready, counter then holds.
      if (rdy_cnt == rdy_cnt_t'(RDY_CYCLES - 1))
        delay_rdy <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/lvds_frame_timer.sv */
// bit position counter and word load strobe,
// one strobe per serial frame.
`timescale 1ns/1ps
`default_nettype none

module lvds_frame_timer (
  input  wire  clk_500m,
  input  wire  rst_n,
  input  wire  lane_rst,
  output logic word_load
);
  import dac_lvds_pkg::*;

  bit_pos_t bit_pos;

  // position of the next serial bit in the frame.
  always_ff @(posedge clk_500m or negedge rst_n)
  begin
    if (!rst_n)
      bit_pos <= '0;
    else if (lane_rst)
      bit_pos <= '0;
    else if (bit_pos == bit_pos_t'(SER_RATIO - 1))
      bit_pos <= '0;
    else
      bit_pos <= bit_pos + 1'b1;
  end

  // position zero stands in for the parallel clock edge.
  assign word_load = (bit_pos == '0) && !lane_rst;

endmodule

`default_nettype wire

/* hdl/oserdes_lane.sv */
// 8:1 parallel to serial shift register,
// lsb first, with lane off clear.
`timescale 1ns/1ps
`default_nettype none

module oserdes_lane (
  input  wire                    clk_500m,
  input  wire                    rst_n,
  input  wire                    lane_off,
  input  wire                    word_load,
  input  dac_lvds_pkg::ser_word_t word,
  output logic                   serial
);
  import dac_lvds_pkg::*;

  // bits still waiting after the current one.
  logic [SER_RATIO-2:0] shift_q;
  logic                 ser_q;

  always_ff @(posedge clk_500m or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '0;
      ser_q   <= 1'b0;
    end
    else if (lane_off)
    begin
      // lane held in reset.
      shift_q <= '0;
      ser_q   <= 1'b0;
    end
    else if (word_load)
    begin
      // bit 0 goes straight out.
      ser_q   <= word[0];
      shift_q <= word[SER_RATIO-1:1];
    end
    else
    begin
      ser_q   <= shift_q[0];
      shift_q <= {1'b0, shift_q[SER_RATIO-2:1]};
    end
  end

  // output is dead for as long as the lane is off.
  assign serial = ser_q & ~lane_off;

endmodule

`default_nettype wire

/* hdl/odelay_line.sv */
// loadable tap register and stage-selected
// delay line for one serial lane.
`timescale 1ns/1ps
`default_nettype none

module odelay_line (
  input  wire               clk_500m,
  input  wire               rst_n,
  input  wire               line_rst,
  input  wire               load,
  input  wire               vtc,
  input  dac_lvds_pkg::tap_t tap_in,
  input  wire               din,
  output logic              dout,
  output dac_lvds_pkg::tap_t tap_out
);
  import dac_lvds_pkg::*;

  tap_t                    tap_q;
  // line_q[k] is din delayed by k cycles.
  logic [DELAY_STAGES-1:1] line_q;
  logic [DELAY_STAGES-1:0] taps;
  stage_sel_t              stage_sel;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tap register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_500m or negedge rst_n)
  begin
    if (!rst_n)
      tap_q <= '0;
    else if (line_rst)
      tap_q <= '0;
    // compensation has to be off for a load.
    else if (load && !vtc)
      tap_q <= tap_in;
  end

  assign tap_out = tap_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift line and stage select.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_500m or negedge rst_n)
  begin
    if (!rst_n)
      line_q <= '0;
    else if (line_rst)
      line_q <= '0;
    else
      line_q <= {line_q[DELAY_STAGES-2:1], din};
  end

  // stage 0 is the undelayed input.
  assign taps = {line_q, din};

  // coarse stage from the upper tap bits.
  assign stage_sel = stage_sel_t'(tap_q / TAPS_PER_STAGE);

  assign dout = taps[stage_sel];

endmodule

`default_nettype wire

/* hdl/dac_lvds_port.sv */
// one dac lvds port: sample transpose, 16 data
// serializers, delayed dclk lane and sync lane.
`timescale 1ns/1ps
`default_nettype none

module dac_lvds_port (
  input  wire                     clk_500m,
  input  wire                     rst_n,
  input  wire                     lane_rst,
  input  wire                     word_load,
  // enables are high for off.
  input  wire                     data_en,
  input  wire                     dclk_en,
  input  wire                     sync_en,
  input  dac_lvds_pkg::dds_word_t dds_in,
  input  dac_lvds_pkg::ser_word_t sync_data,
  input  wire                     delay_load,
  input  wire                     delay_vtc,
  input  dac_lvds_pkg::tap_t      delay_value,
  output dac_lvds_pkg::tap_t      delay_result,
  output dac_lvds_pkg::lane_bus_t data_p,
  output dac_lvds_pkg::lane_bus_t data_n,
  output logic                    dclk_p,
  output logic                    dclk_n,
  output logic                    sync_p,
  output logic                    sync_n
);
  import dac_lvds_pkg::*;

  sample_t   samples   [SER_RATIO];
  ser_word_t lane_word [LANES];
  lane_bus_t data_ser;
  logic      data_off;
  logic      dclk_off;
  logic      dclk_ser;
  logic      dclk_dly;
  logic      sync_ser;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sample transpose.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lane i carries bit i of s0..s7, s0 first out.
  always_comb
  begin
    for (int s = 0; s < SER_RATIO; s++)
      samples[s] = dds_in[s*SAMPLE_W +: SAMPLE_W];
    for (int i = 0; i < LANES; i++)
      for (int s = 0; s < SER_RATIO; s++)
        lane_word[i][s] = samples[s][i];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data lanes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign data_off = lane_rst | data_en;

  for (genvar i = 0; i < LANES; i++)
  begin : g_data
    oserdes_lane i_ser (
      .clk_500m  (clk_500m),
      .rst_n     (rst_n),
      .lane_off  (data_off),
      .word_load (word_load),
      .word      (lane_word[i]),
      .serial    (data_ser[i])
    );
  end

  // differential pairs.
  assign data_p = data_ser;
  assign data_n = ~data_ser;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // dclk lane with tap delay.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // dclk_en also resets the delay taps.
  assign dclk_off = lane_rst | dclk_en;

  oserdes_lane i_dclk_ser (
    .clk_500m  (clk_500m),
    .rst_n     (rst_n),
    .lane_off  (dclk_off),
    .word_load (word_load),
    .word      (DCLK_PATTERN),
    .serial    (dclk_ser)
  );

  odelay_line i_dclk_dly (
    .clk_500m (clk_500m),
    .rst_n    (rst_n),
    .line_rst (dclk_off),
    .load     (delay_load),
    .vtc      (delay_vtc),
    .tap_in   (delay_value),
    .din      (dclk_ser),
    .dout     (dclk_dly),
    .tap_out  (delay_result)
  );

  assign dclk_p = dclk_dly;
  assign dclk_n = ~dclk_dly;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sync lane.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // keeps shifting under sync_en; only the pin is gated.
  oserdes_lane i_sync_ser (
    .clk_500m  (clk_500m),
    .rst_n     (rst_n),
    .lane_off  (lane_rst),
    .word_load (word_load),
    .word      (sync_data),
    .serial    (sync_ser)
  );

  assign sync_p = sync_ser & ~sync_en;
  assign sync_n = ~sync_p;

endmodule

`default_nettype wire

/* hdl/dac_lvds_out.sv */
// dual dac lvds output top: shared reset release,
// frame timer and two port instances.
`timescale 1ns/1ps
`default_nettype none

module dac_lvds_out (
  input  wire                     clk_500m,
  input  wire                     rst_n,
  output logic                    sample_req,
  output logic                    delay_rdy,
  // port 1.
  input  wire                     sync_en_1,
  input  wire                     dclk_en_1,
  input  wire                     data_en_1,
  input  dac_lvds_pkg::ser_word_t sync_1_data,
  input  dac_lvds_pkg::dds_word_t dds_1_in,
  input  wire                     delay_load_1,
  input  wire                     delay_vtc_1,
  input  dac_lvds_pkg::tap_t      delay_value_1,
  output dac_lvds_pkg::tap_t      delay_result_1,
  output logic                    dac1_sync_p,
  output logic                    dac1_sync_n,
  output logic                    dac1_dclk_p,
  output logic                    dac1_dclk_n,
  output dac_lvds_pkg::lane_bus_t dac1_data_p,
  output dac_lvds_pkg::lane_bus_t dac1_data_n,
  // port 2.
  input  wire                     sync_en_2,
  input  wire                     dclk_en_2,
  input  wire                     data_en_2,
  input  dac_lvds_pkg::ser_word_t sync_2_data,
  input  dac_lvds_pkg::dds_word_t dds_2_in,
  input  wire                     delay_load_2,
  input  wire                     delay_vtc_2,
  input  dac_lvds_pkg::tap_t      delay_value_2,
  output dac_lvds_pkg::tap_t      delay_result_2,
  output logic                    dac2_sync_p,
  output logic                    dac2_sync_n,
  output logic                    dac2_dclk_p,
  output logic                    dac2_dclk_n,
  output dac_lvds_pkg::lane_bus_t dac2_data_p,
  output dac_lvds_pkg::lane_bus_t dac2_data_n
);

  logic lane_rst;
  logic word_load;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shared control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  lvds_reset_ctrl i_rst_ctrl (
    .clk_500m  (clk_500m),
    .rst_n     (rst_n),
    .lane_rst  (lane_rst),
    .delay_rdy (delay_rdy)
  );

  lvds_frame_timer i_frame (
    .clk_500m  (clk_500m),
    .rst_n     (rst_n),
    .lane_rst  (lane_rst),
    .word_load (word_load)
  );

  // upstream sees the load strobe as its request.
  assign sample_req = word_load;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // dac ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  dac_lvds_port i_port_1 (
    .clk_500m     (clk_500m),
    .rst_n        (rst_n),
    .lane_rst     (lane_rst),
    .word_load    (word_load),
    .data_en      (data_en_1),
    .dclk_en      (dclk_en_1),
    .sync_en      (sync_en_1),
    .dds_in       (dds_1_in),
    .sync_data    (sync_1_data),
    .delay_load   (delay_load_1),
    .delay_vtc    (delay_vtc_1),
    .delay_value  (delay_value_1),
    .delay_result (delay_result_1),
    .data_p       (dac1_data_p),
    .data_n       (dac1_data_n),
    .dclk_p       (dac1_dclk_p),
    .dclk_n       (dac1_dclk_n),
    .sync_p       (dac1_sync_p),
    .sync_n       (dac1_sync_n)
  );

  dac_lvds_port i_port_2 (
    .clk_500m     (clk_500m),
    .rst_n        (rst_n),
    .lane_rst     (lane_rst),
    .word_load    (word_load),
    .data_en      (data_en_2),
    .dclk_en      (dclk_en_2),
    .sync_en      (sync_en_2),
    .dds_in       (dds_2_in),
    .sync_data    (sync_2_data),
    .delay_load   (delay_load_2),
    .delay_vtc    (delay_vtc_2),
    .delay_value  (delay_value_2),
    .delay_result (delay_result_2),
    .data_p       (dac2_data_p),
    .data_n       (dac2_data_n),
    .dclk_p       (dac2_dclk_p),
    .dclk_n       (dac2_dclk_n),
    .sync_p       (dac2_sync_p),
    .sync_n       (dac2_sync_n)
  );

endmodule

`default_nettype wire

/* tests/tb_dac_lvds_out.sv */
// testbench for the dual dac lvds output, stimulus
// and frame settings from the testdata file.
`timescale 1ns/1ps
`default_nettype none

module tb_dac_lvds_out;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // expected timing and words.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int       FIELDS    = 7;
  localparam int       MAX_WORDS = FIELDS * 32;
  localparam int       RDY_DELAY = 10 + 16;
  localparam int       TIMEOUT   = 200;
  localparam logic [7:0] DCLK_WORD = 8'b1010_1010;

  logic clk_500m;
  logic rst_n;
  logic sample_req;
  logic delay_rdy;

  // port 1 pins.
  logic sync_en_1, dclk_en_1, data_en_1, delay_load_1, delay_vtc_1;
  logic [7:0]   sync_1_data;
  logic [127:0] dds_1_in;
  logic [8:0]   delay_value_1, delay_result_1;
  logic dac1_sync_p, dac1_sync_n, dac1_dclk_p, dac1_dclk_n;
  logic [15:0]  dac1_data_p, dac1_data_n;
  // port 2 pins.
  logic sync_en_2, dclk_en_2, data_en_2, delay_load_2, delay_vtc_2;
  logic [7:0]   sync_2_data;
  logic [127:0] dds_2_in;
  logic [8:0]   delay_value_2, delay_result_2;
  logic dac2_sync_p, dac2_sync_n, dac2_dclk_p, dac2_dclk_n;
  logic [15:0]  dac2_data_p, dac2_data_n;

  // file image and per port model state.
  logic [127:0] tdata [0:MAX_WORDS-1];
  logic [127:0] exp_dds  [1:2];
  logic [7:0]   exp_sync [1:2];
  logic [2:0]   exp_en   [1:2];
  logic [8:0]   exp_tap  [1:2];
  // bit j is the dclk serializer output j cycles back.
  logic [7:0]   dhist    [1:2];

  dac_lvds_out i_dut (
    .clk_500m (clk_500m), .rst_n (rst_n),
    .sample_req (sample_req), .delay_rdy (delay_rdy),
    .sync_en_1 (sync_en_1), .dclk_en_1 (dclk_en_1), .data_en_1 (data_en_1),
    .sync_1_data (sync_1_data), .dds_1_in (dds_1_in),
    .delay_load_1 (delay_load_1), .delay_vtc_1 (delay_vtc_1),
    .delay_value_1 (delay_value_1), .delay_result_1 (delay_result_1),
    .dac1_sync_p (dac1_sync_p), .dac1_sync_n (dac1_sync_n),
    .dac1_dclk_p (dac1_dclk_p), .dac1_dclk_n (dac1_dclk_n),
    .dac1_data_p (dac1_data_p), .dac1_data_n (dac1_data_n),
    .sync_en_2 (sync_en_2), .dclk_en_2 (dclk_en_2), .data_en_2 (data_en_2),
    .sync_2_data (sync_2_data), .dds_2_in (dds_2_in),
    .delay_load_2 (delay_load_2), .delay_vtc_2 (delay_vtc_2),
    .delay_value_2 (delay_value_2), .delay_result_2 (delay_result_2),
    .dac2_sync_p (dac2_sync_p), .dac2_sync_n (dac2_sync_n),
    .dac2_dclk_p (dac2_dclk_p), .dac2_dclk_n (dac2_dclk_n),
    .dac2_data_p (dac2_data_p), .dac2_data_n (dac2_data_n)
  );

  // 10 ns clock.
  always #5 clk_500m = ~clk_500m;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: %s got %0h expected %0h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  endtask

  // one clock step, sampling point just after the edge.
  task automatic step_cycle;
    @(posedge clk_500m);
    #1;
  endtask

  // copy a port's pins into plain variables.
  task automatic read_port(input int p, output logic [15:0] dp, output logic [15:0] dn,
                           output logic [3:0] pins, output logic [8:0] res);
    if (p == 1)
    begin
      dp   = dac1_data_p;
      dn   = dac1_data_n;
      pins = {dac1_dclk_p, dac1_dclk_n, dac1_sync_p, dac1_sync_n};
      res  = delay_result_1;
    end
    else
    begin
      dp   = dac2_data_p;
      dn   = dac2_data_n;
      pins = {dac2_dclk_p, dac2_dclk_n, dac2_sync_p, dac2_sync_n};
      res  = delay_result_2;
    end
  endtask

  // idle pins: p low, n high, no tap.
  task automatic check_idle_pins;
    logic [15:0] dp;
    logic [15:0] dn;
    logic [3:0]  pins;
    logic [8:0]  res;
    for (int p = 1; p <= 2; p++)
    begin
      read_port(p, dp, dn, pins, res);
      check_value(128'(dp), 128'(16'h0000), "idle data_p");
      check_value(128'(dn), 128'(16'hffff), "idle data_n");
      check_value(128'(pins), 128'(4'b0101), "idle dclk/sync pins");
      check_value(128'(res), 128'(9'd0), "idle delay_result");
    end
  endtask

  task automatic wait_sample_req;
    int n;
    n = 0;
    while (sample_req !== 1'b1)
    begin
      if (n >= TIMEOUT)
        report_timeout("sample_req");
      step_cycle();
      n++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus and per cycle checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_port(input int p, input logic load, input logic vtc,
                            input logic [8:0] tap);
    if (p == 1)
    begin
      dds_1_in      = exp_dds[1];
      sync_1_data   = exp_sync[1];
      {data_en_1, dclk_en_1, sync_en_1} = exp_en[1];
      delay_load_1  = load;
      delay_vtc_1   = vtc;
      delay_value_1 = tap;
    end
    else
    begin
      dds_2_in      = exp_dds[2];
      sync_2_data   = exp_sync[2];
      {data_en_2, dclk_en_2, sync_en_2} = exp_en[2];
      delay_load_2  = load;
      delay_vtc_2   = vtc;
      delay_value_2 = tap;
    end
  endtask

  // bit k of the frame on one port.
  task automatic check_port_bit(input int p, input int k);
    logic [15:0] dp;
    logic [15:0] dn;
    logic [3:0]  pins;
    logic [8:0]  res;
    logic [15:0] exp_data;
    logic [15:0] exp_data_n;
    logic        din;
    logic        exp_dclk;
    logic        exp_sync_p;
    int          stage;
    read_port(p, dp, dn, pins, res);
    // lane i shows bit i of sample k.
    exp_data   = exp_en[p][2] ? 16'h0000 : exp_dds[p][k*16 +: 16];
    exp_data_n = ~exp_data;
    // dclk lane off also clears its delay line.
    if (exp_en[p][1])
      dhist[p] = 8'h00;
    else
    begin
      din      = DCLK_WORD[k];
      dhist[p] = {dhist[p][6:0], din};
    end
    stage      = int'(exp_tap[p]) / 64;
    exp_dclk   = dhist[p][stage];
    exp_sync_p = exp_en[p][0] ? 1'b0 : exp_sync[p][k];
    check_value(128'(dp), 128'(exp_data), $sformatf("port %0d data_p bit %0d", p, k));
    check_value(128'(dn), 128'(exp_data_n), $sformatf("port %0d data_n bit %0d", p, k));
    check_value(128'(pins[3:2]), 128'({exp_dclk, ~exp_dclk}),
                $sformatf("port %0d dclk pair bit %0d", p, k));
    check_value(128'(pins[1:0]), 128'({exp_sync_p, ~exp_sync_p}),
                $sformatf("port %0d sync pair bit %0d", p, k));
    check_value(128'(res), 128'(exp_tap[p]), $sformatf("port %0d delay_result", p));
  endtask

  // one data file line, applied at a sample_req.
  task automatic run_frame(input int base);
    int          p;
    logic [2:0]  en;
    logic [8:0]  tap;
    logic        load;
    logic        vtc;
    p    = int'(tdata[base][1:0]);
    en   = tdata[base+3][2:0];
    tap  = tdata[base+4][8:0];
    load = tdata[base+5][0];
    vtc  = tdata[base+6][0];
    exp_dds[p]  = tdata[base+1];
    exp_sync[p] = tdata[base+2][7:0];
    exp_en[p]   = en;
    // tap model, lane off wins over a load.
    for (int q = 1; q <= 2; q++)
      if (exp_en[q][1])
        exp_tap[q] = 9'd0;
    if (!en[1] && load && !vtc)
      exp_tap[p] = tap;
    drive_port(p, load, vtc, tap);
    for (int k = 0; k < 8; k++)
    begin
      step_cycle();
      check_port_bit(1, k);
      check_port_bit(2, k);
      // strobe only at the frame boundary.
      check_value(128'(sample_req), 128'(k == 7), $sformatf("sample_req at bit %0d", k));
      if (k == 0)
      begin
        delay_load_1 = 1'b0;
        delay_load_2 = 1'b0;
      end
      // sync gate lifted mid frame, byte keeps shifting under it.
      if (k == 3 && en[0])
      begin
        exp_en[p][0] = 1'b0;
        if (p == 1)
          sync_en_1 = 1'b0;
        else
          sync_en_2 = 1'b0;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    int n;
    int base;
    clk_500m = 1'b0;
    rst_n    = 1'b0;
    for (int q = 1; q <= 2; q++)
    begin
      exp_dds[q]  = '0;
      exp_sync[q] = 8'hff;
      exp_en[q]   = 3'b000;
      exp_tap[q]  = 9'd0;
      // dclk runs from reset release, so history is the word.
      for (int j = 0; j < 8; j++)
        dhist[q][j] = DCLK_WORD[7-j];
      drive_port(q, 1'b0, 1'b0, 9'd0);
    end
    for (int i = 0; i < MAX_WORDS; i++)
      tdata[i] = '0;
    $readmemh("tests/dac_lvds_testdata.txt", tdata);

    // reset for 4 cycles.
    repeat (4) @(posedge clk_500m);
    #1;
    check_idle_pins();
    rst_n = 1'b1;
    check_value(128'(sample_req), 128'(1'b0), "sample_req after reset");
    check_value(128'(delay_rdy), 128'(1'b0), "delay_rdy after reset");

    // ready comes a fixed count after release.
    n = 0;
    while (delay_rdy !== 1'b1)
    begin
      if (n >= TIMEOUT)
        report_timeout("delay_rdy");
      step_cycle();
      n++;
    end
    check_value(128'(n), 128'(RDY_DELAY), "cycles from reset release to delay_rdy");

    base = 0;
    while (base + FIELDS <= MAX_WORDS && tdata[base][1:0] != 2'd0)
    begin
      wait_sample_req();
      run_frame(base);
      base += FIELDS;
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/dac_lvds_pkg.sv
hdl/lvds_reset_ctrl.sv
hdl/lvds_frame_timer.sv
hdl/oserdes_lane.sv
hdl/odelay_line.sv
hdl/dac_lvds_port.sv
hdl/dac_lvds_out.sv
tests/tb_dac_lvds_out.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dual DAC LVDS testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

verilator --binary --timing -f all.f --top-module tb_dac_lvds_out \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
  echo "failure reported in $LOG"
  exit 1
fi

if [ ! -s "$LOG" ]; then
  echo "simulation log is empty"
  exit 1
fi

echo "simulation finished without failures"
exit 0

/* tests/dac_lvds_testdata.txt */
// port dds_word(s7..s0) sync_byte enables(data,dclk,sync) tap load vtc
// one frame per line, port 0 ends the list
1 0123456789abcdeffedcba9876543210 ff 0 000 0 0
2 80004000200010000800040002000100 fb 0 000 0 0
1 a5a55a5affff000012343210deadbeef fb 0 0c8 1 0
2 11112222333344445555666677778888 ff 0 1c0 1 0
1 7fff8001000100027ffe80007f008000 5a 4 000 1 1
2 0f0f0f0ff0f0f0f000ff00ffff00ff00 a5 1 040 1 0
1 cafebabe0000ffff5555aaaa12121212 fb 2 000 0 0
1 00000000000000000000000000000001 80 0 0ff 1 0
2 deadbeefdeadbeefdeadbeefdeadbeef fb 7 000 0 0
2 fedcba98765432100123456789abcdef 01 0 1ff 1 0
1 ffffffffffffffffffffffffffffffff ff 0 080 1 1
2 13579bdf2468ace0fdb97531eca86420 00 0 000 0 0
1 0000ffff0000ffff0000ffff0000ffff fb 1 100 1 0
0 0 0 0 0 0 0
